// ==== verilog/soc_pkg.sv ====
/* bus widths, address map and APB structs for the peripheral subsystem.
   the slave select field is two bits, so num_slaves may not exceed four */
package soc_pkg;

    ////////////////////////////////////////
    // widths and counts
    ////////////////////////////////////////
    localparam int addr_width        = 16;
    localparam int data_width        = 16;
    localparam int num_masters       = 2;
    localparam int num_slaves        = 4;
    localparam int master_bits       = $clog2(num_masters);
    localparam int reset_hold_cycles = 8;

    ////////////////////////////////////////
    // address map
    ////////////////////////////////////////
    localparam int slave_sel_lsb  = 8;
    localparam int slave_sel_bits = 2;
    localparam int slave_gpio0    = 0;
    localparam int slave_gpio1    = 1;
    localparam int slave_gpio2    = 2;
    localparam int slave_info     = 3;
    localparam int gpio0_pins     = 8;
    localparam int gpio1_pins     = 16;
    localparam int gpio2_pins     = 8;
    localparam int info_cells     = 8;
    localparam int info_idx_bits  = $clog2(info_cells);

    // request from a master, or the shared request towards the slaves
    typedef struct packed {
        logic [addr_width-1:0] paddr;
        logic                  pwrite;
        logic                  psel;
        logic                  penable;
        logic [data_width-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [data_width-1:0] prdata;
        logic                  pready;
    } apb_rsp_t;

endpackage

// ==== verilog/reset_stretch.sv ====
/* external reset must be asserted once at power up to load the counter */
module reset_stretch (
    input  logic clk,
    input  logic reset,
    output logic reset_hold
);

    localparam int cnt_bits = $clog2(soc_pkg::reset_hold_cycles + 1);

    logic [cnt_bits-1:0] hold_cnt;

    // reload while the external reset is high, then count down to zero
    always_ff @(posedge clk) begin
        if (reset) begin
            hold_cnt <= cnt_bits'(soc_pkg::reset_hold_cycles);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // high during external reset and for reset_hold_cycles after it
    assign reset_hold = reset | (hold_cnt != '0);

endmodule

// ==== verilog/apb_intercon.sv ====
/* one transfer at a time on the shared bus; masters must hold their request
   until pready. slaves are selected by paddr[slave_sel_lsb +: slave_sel_bits] */
module apb_intercon (
    input  logic              clk,
    input  logic              reset,
    input  soc_pkg::apb_req_t m_req [soc_pkg::num_masters],
    output soc_pkg::apb_rsp_t m_rsp [soc_pkg::num_masters],
    output soc_pkg::apb_req_t s_req,
    output logic [soc_pkg::num_slaves-1:0] s_sel,
    input  soc_pkg::apb_rsp_t s_rsp [soc_pkg::num_slaves]
);

    typedef enum logic [1:0] {
        ph_idle,
        ph_setup,
        ph_access
    } phase_t;

    phase_t                            phase;
    logic [soc_pkg::master_bits-1:0]   grant;
    logic [soc_pkg::master_bits-1:0]   next_grant;
    logic                              pick_valid;
    logic [soc_pkg::slave_sel_bits-1:0] slave_idx;
    soc_pkg::apb_rsp_t                 sel_rsp;

    ////////////////////////////////////////
    // round robin pick
    ////////////////////////////////////////
    // search starts one past the master served last
    always_comb begin
        int cand;
        next_grant = grant;
        pick_valid = 1'b0;
        for (int i = 1; i <= soc_pkg::num_masters; i++) begin
            cand = (int'(grant) + i) % soc_pkg::num_masters;
            if (!pick_valid && m_req[cand].psel) begin
                next_grant = cand[soc_pkg::master_bits-1:0];
                pick_valid = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // phase FSM
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= ph_idle;
            // master 0 wins the first pick
            grant <= soc_pkg::master_bits'(soc_pkg::num_masters - 1);
        end else begin
            case (phase)
                ph_idle: begin
                    if (pick_valid) begin
                        grant <= next_grant;
                        phase <= ph_setup;
                    end
                end
                ph_setup: begin
                    phase <= ph_access;
                end
                ph_access: begin
                    if (sel_rsp.pready) begin
                        phase <= ph_idle;
                    end
                end
                default: begin
                    phase <= ph_idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // shared request and slave decode
    ////////////////////////////////////////
    always_comb begin
        s_req         = m_req[grant];
        s_req.psel    = (phase != ph_idle);
        s_req.penable = (phase == ph_access);
    end

    assign slave_idx = s_req.paddr[soc_pkg::slave_sel_lsb +: soc_pkg::slave_sel_bits];
    assign sel_rsp   = s_rsp[slave_idx];

    always_comb begin
        for (int s = 0; s < soc_pkg::num_slaves; s++) begin
            s_sel[s] = (phase != ph_idle) && (slave_idx == soc_pkg::slave_sel_bits'(s));
        end
    end

    // response goes back to the granted master only, during access
    always_comb begin
        for (int m = 0; m < soc_pkg::num_masters; m++) begin
            m_rsp[m] = '0;
            if (phase == ph_access && grant == soc_pkg::master_bits'(m)) begin
                m_rsp[m] = sel_rsp;
            end
        end
    end

endmodule

// ==== verilog/gpio_apb.sv ====
/* output-only pins, no wait states; pins must not exceed data_width.
   reads return the pin register zero-extended */
module gpio_apb #(
    parameter int pins = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  soc_pkg::apb_req_t req,
    input  logic              sel,
    output soc_pkg::apb_rsp_t rsp,
    output logic [pins-1:0]   gpio
);

    logic [pins-1:0] pin_reg;
    logic            access;

    // access phase of a transfer aimed at this slave
    assign access = sel & req.psel & req.penable;

    always_ff @(posedge clk) begin
        if (reset) begin
            pin_reg <= '0;
        end else if (access && req.pwrite) begin
            pin_reg <= req.pwdata[pins-1:0];
        end
    end

    assign gpio = pin_reg;

    always_comb begin
        rsp.prdata = soc_pkg::data_width'(pin_reg);
        rsp.pready = access;
    end

endmodule

// ==== verilog/info_regs_apb.sv ====
/* registers 0 and 1 are read-only system counts; writes to them are dropped.
   only paddr bits 2:0 are decoded, higher bits alias */
module info_regs_apb (
    input  logic              clk,
    input  logic              reset,
    input  soc_pkg::apb_req_t req,
    input  logic              sel,
    output soc_pkg::apb_rsp_t rsp
);

    logic [soc_pkg::data_width-1:0]    scratch [2:soc_pkg::info_cells-1];
    logic [soc_pkg::info_idx_bits-1:0] idx;
    logic                              access;

    assign access = sel & req.psel & req.penable;
    assign idx    = req.paddr[soc_pkg::info_idx_bits-1:0];

    ////////////////////////////////////////
    // scratch writes
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 2; i < soc_pkg::info_cells; i++) begin
                scratch[i] <= '0;
            end
        end else if (access && req.pwrite && idx >= 2) begin
            scratch[idx] <= req.pwdata;
        end
    end

    ////////////////////////////////////////
    // read mux
    ////////////////////////////////////////
    always_comb begin
        case (idx)
            0: begin
                rsp.prdata = soc_pkg::data_width'(soc_pkg::num_masters);
            end
            1: begin
                rsp.prdata = soc_pkg::data_width'(soc_pkg::num_slaves);
            end
            default: begin
                rsp.prdata = scratch[idx];
            end
        endcase
        // never stalls
        rsp.pready = access;
    end

endmodule

// ==== verilog/periph_soc.sv ====
/* two external APB masters share four slaves; the external reset is
   stretched by reset_hold_cycles before the bus leaves reset */
module periph_soc (
    input  logic                             clk,
    input  logic                             reset,
    input  soc_pkg::apb_req_t                m_req [soc_pkg::num_masters],
    output soc_pkg::apb_rsp_t                m_rsp [soc_pkg::num_masters],
    output logic [soc_pkg::gpio0_pins-1:0]   gpio0,
    output logic [soc_pkg::gpio1_pins-1:0]   gpio1,
    output logic [soc_pkg::gpio2_pins-1:0]   gpio2
);

    logic                            reset_hold;
    soc_pkg::apb_req_t               s_req;
    logic [soc_pkg::num_slaves-1:0]  s_sel;
    soc_pkg::apb_rsp_t               s_rsp [soc_pkg::num_slaves];

    reset_stretch rst_i (
        .clk        (clk),
        .reset      (reset),
        .reset_hold (reset_hold)
    );

    apb_intercon bus_i (
        .clk   (clk),
        .reset (reset_hold),
        .m_req (m_req),
        .m_rsp (m_rsp),
        .s_req (s_req),
        .s_sel (s_sel),
        .s_rsp (s_rsp)
    );

    ////////////////////////////////////////
    // slaves
    ////////////////////////////////////////
    gpio_apb #(.pins(soc_pkg::gpio0_pins)) gpio0_i (
        .clk   (clk),
        .reset (reset_hold),
        .req   (s_req),
        .sel   (s_sel[soc_pkg::slave_gpio0]),
        .rsp   (s_rsp[soc_pkg::slave_gpio0]),
        .gpio  (gpio0)
    );

    // 16 pins, e.g. two seven segment digits
    gpio_apb #(.pins(soc_pkg::gpio1_pins)) gpio1_i (
        .clk   (clk),
        .reset (reset_hold),
        .req   (s_req),
        .sel   (s_sel[soc_pkg::slave_gpio1]),
        .rsp   (s_rsp[soc_pkg::slave_gpio1]),
        .gpio  (gpio1)
    );

    gpio_apb #(.pins(soc_pkg::gpio2_pins)) gpio2_i (
        .clk   (clk),
        .reset (reset_hold),
        .req   (s_req),
        .sel   (s_sel[soc_pkg::slave_gpio2]),
        .rsp   (s_rsp[soc_pkg::slave_gpio2]),
        .gpio  (gpio2)
    );

    info_regs_apb info_i (
        .clk   (clk),
        .reset (reset_hold),
        .req   (s_req),
        .sel   (s_sel[soc_pkg::slave_info]),
        .rsp   (s_rsp[soc_pkg::slave_info])
    );

endmodule

// ==== testbench/tb_clock.sv ====
/* free-running clock, 4 ns period, starts low */
module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

endmodule

// ==== testbench/apb_intercon_properties.sv ====
/* handshake rules of the interconnect. the reset rule is checked from the
   second reset cycle on, once the phase register holds a known value */
module apb_intercon_properties (
    input logic                           clk,
    input logic                           reset,
    input soc_pkg::apb_req_t              m_req [soc_pkg::num_masters],
    input soc_pkg::apb_rsp_t              m_rsp [soc_pkg::num_masters],
    input logic [soc_pkg::num_slaves-1:0] s_sel
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [soc_pkg::num_masters-1:0] ready_vec;
    logic [soc_pkg::num_masters-1:0] psel_vec;

    always_comb begin
        for (int m = 0; m < soc_pkg::num_masters; m++) begin
            ready_vec[m] = m_rsp[m].pready;
            psel_vec[m]  = m_req[m].psel;
        end
    end

    // pready only to a master that is requesting
    ready_needs_psel: assert property (@(posedge clk) disable iff (reset)
        (ready_vec & ~psel_vec) == '0)
        else $error("pready given to a master whose psel is low");

    one_ready: assert property (@(posedge clk) disable iff (reset) $onehot0(ready_vec))
        else $error("more than one master got pready in the same cycle");

    quiet_in_reset: assert property (@(posedge clk)
        reset && $past(reset) |-> ready_vec == '0 && s_sel == '0)
        else $error("pready or shared psel active during reset");

endmodule

bind apb_intercon apb_intercon_properties props_i (
    .clk   (clk),
    .reset (reset),
    .m_req (m_req),
    .m_rsp (m_rsp),
    .s_sel (s_sel)
);

// ==== testbench/periph_soc_tb.sv ====
/* directed tests of the peripheral subsystem; the run stops at the first
   failing check. every task starts and ends on a rising clock edge */
module periph_soc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int wait_limit   = 100;
    localparam int reset_cycles = 4;
    localparam int fair_rounds  = 10;
    localparam int pin_max      = soc_pkg::gpio1_pins;
    // psel driven at one edge is seen at the next and pready two edges after that
    localparam int free_latency = 3;

    logic                           clk;
    logic                           reset;
    soc_pkg::apb_req_t              m_req [soc_pkg::num_masters];
    soc_pkg::apb_rsp_t              m_rsp [soc_pkg::num_masters];
    logic [soc_pkg::gpio0_pins-1:0] gpio0;
    logic [soc_pkg::gpio1_pins-1:0] gpio1;
    logic [soc_pkg::gpio2_pins-1:0] gpio2;
    logic [31:0]                    lfsr_state;
    int                             done_order [$];

    tb_clock clk_i (.clk(clk));

    periph_soc dut_i (
        .clk   (clk),
        .reset (reset),
        .m_req (m_req),
        .m_rsp (m_rsp),
        .gpio0 (gpio0),
        .gpio1 (gpio1),
        .gpio2 (gpio2)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_data(input logic [soc_pkg::data_width-1:0] got,
                              input logic [soc_pkg::data_width-1:0] exp, input string what);
        if (got !== exp) begin
            stop_on_failure($sformatf("ERROR at %0t: %s read 0x%04h, expected 0x%04h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_pins(input logic [pin_max-1:0] got, input logic [pin_max-1:0] exp,
                              input string what);
        if (got !== exp) begin
            stop_on_failure($sformatf("ERROR at %0t: %s pins 0x%04h, expected 0x%04h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            stop_on_failure($sformatf("ERROR at %0t: %s took %0d cycles, expected %0d",
                                      $time, what, got, exp));
        end
    endtask

    // galois form of x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'hd000_0001;
        end
        return n;
    endfunction

    function automatic logic [soc_pkg::data_width-1:0] random_word();
        logic [soc_pkg::data_width-1:0] w;
        w = '0;
        for (int i = 0; i < soc_pkg::data_width; i++) begin
            w = {w[soc_pkg::data_width-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return w;
    endfunction

    function automatic logic [soc_pkg::addr_width-1:0] slave_addr(input int s, input int r);
        return soc_pkg::addr_width'((s << soc_pkg::slave_sel_lsb) | r);
    endfunction

    function automatic logic [pin_max-1:0] current_pins(input int s);
        case (s)
            soc_pkg::slave_gpio0: return pin_max'(gpio0);
            soc_pkg::slave_gpio1: return pin_max'(gpio1);
            default: return pin_max'(gpio2);
        endcase
    endfunction

    ////////////////////////////////////////
    // master drivers
    ////////////////////////////////////////
    task automatic apb_transfer(input int m, input logic [soc_pkg::addr_width-1:0] addr,
                                input logic write, input logic [soc_pkg::data_width-1:0] wdata,
                                output logic [soc_pkg::data_width-1:0] rdata,
                                output int cycles);
        soc_pkg::apb_req_t req;
        logic              done;
        req        = '0;
        req.paddr  = addr;
        req.pwrite = write;
        req.psel   = 1'b1;
        req.pwdata = wdata;
        m_req[m] <= req;
        done   = 1'b0;
        cycles = 0;
        rdata  = '0;
        while (!done) begin
            @(posedge clk);
            cycles++;
            if (m_rsp[m].pready) begin
                rdata = m_rsp[m].prdata;
                m_req[m] <= '0;
                done = 1'b1;
            end else if (cycles >= wait_limit) begin
                stop_on_failure($sformatf("timeout: master %0d saw no pready in %0d cycles",
                                          m, wait_limit));
            end else begin
                req.penable = 1'b1;
                m_req[m] <= req;
            end
        end
    endtask

    task automatic run_both(input logic [soc_pkg::addr_width-1:0] addr0, input logic write0,
                            input logic [soc_pkg::data_width-1:0] wdata0,
                            input logic [soc_pkg::addr_width-1:0] addr1, input logic write1,
                            input logic [soc_pkg::data_width-1:0] wdata1,
                            output logic [soc_pkg::data_width-1:0] rdata0,
                            output logic [soc_pkg::data_width-1:0] rdata1);
        int cycles0;
        int cycles1;
        fork
            apb_transfer(0, addr0, write0, wdata0, rdata0, cycles0);
            apb_transfer(1, addr1, write1, wdata1, rdata1, cycles1);
        join
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic verify_reset_stretch();
        logic [soc_pkg::data_width-1:0] wdata;
        logic [soc_pkg::data_width-1:0] rdata;
        int                             cycles;
        wdata = random_word();
        for (int s = 0; s < 3; s++) begin
            check_pins(current_pins(s), '0, $sformatf("gpio%0d at reset release", s));
        end
        reset <= 1'b0;
        fork
            apb_transfer(0, slave_addr(soc_pkg::slave_gpio0, 0), 1'b1, wdata, rdata, cycles);
            begin
                for (int k = 0; k < soc_pkg::reset_hold_cycles; k++) begin
                    @(posedge clk);
                    check_pins(current_pins(0), '0, "gpio0 during reset hold");
                end
            end
        join
        check_latency(cycles, soc_pkg::reset_hold_cycles + free_latency, "write at release");
        @(posedge clk);
        check_pins(current_pins(0), pin_max'(wdata[soc_pkg::gpio0_pins-1:0]), "gpio0 after hold");
    endtask

    task automatic gpio_slave_check(input int s, input int pins);
        logic [soc_pkg::data_width-1:0] wdata;
        logic [soc_pkg::data_width-1:0] rdata;
        logic [soc_pkg::data_width-1:0] exp;
        int                             cycles;
        wdata = random_word();
        exp   = wdata & soc_pkg::data_width'((32'd1 << pins) - 32'd1);
        apb_transfer(s % 2, slave_addr(s, 0), 1'b1, wdata, rdata, cycles);
        check_latency(cycles, free_latency, $sformatf("write to gpio%0d", s));
        @(posedge clk);
        check_pins(current_pins(s), pin_max'(exp), $sformatf("gpio%0d after write", s));
        apb_transfer((s + 1) % 2, slave_addr(s, 0), 1'b0, '0, rdata, cycles);
        check_data(rdata, exp, $sformatf("gpio%0d readback", s));
    endtask

    task automatic info_register_checks();
        logic [soc_pkg::data_width-1:0] expected [soc_pkg::info_cells];
        logic [soc_pkg::data_width-1:0] rdata;
        logic [soc_pkg::data_width-1:0] exp;
        int                             cycles;
        // count registers read before and after a write attempt
        for (int r = 0; r < 2; r++) begin
            // two masters and four slaves
            exp = (r == 0) ? soc_pkg::data_width'(2) : soc_pkg::data_width'(4);
            apb_transfer(0, slave_addr(soc_pkg::slave_info, r), 1'b0, '0, rdata, cycles);
            check_data(rdata, exp, $sformatf("info register %0d", r));
            apb_transfer(1, slave_addr(soc_pkg::slave_info, r), 1'b1, random_word(), rdata, cycles);
            apb_transfer(0, slave_addr(soc_pkg::slave_info, r), 1'b0, '0, rdata, cycles);
            check_data(rdata, exp, $sformatf("info register %0d after write", r));
        end
        for (int r = 2; r < soc_pkg::info_cells; r++) begin
            apb_transfer(1, slave_addr(soc_pkg::slave_info, r), 1'b0, '0, rdata, cycles);
            check_data(rdata, '0, $sformatf("info register %0d after reset", r));
            expected[r] = random_word();
            apb_transfer(r % 2, slave_addr(soc_pkg::slave_info, r), 1'b1, expected[r], rdata,
                         cycles);
        end
        // rewrite one cell while the others keep their values
        expected[4] = random_word();
        apb_transfer(1, slave_addr(soc_pkg::slave_info, 4), 1'b1, expected[4], rdata, cycles);
        for (int r = soc_pkg::info_cells - 1; r >= 2; r--) begin
            apb_transfer(0, slave_addr(soc_pkg::slave_info, r), 1'b0, '0, rdata, cycles);
            check_data(rdata, expected[r], $sformatf("info register %0d", r));
        end
    endtask

    task automatic concurrent_masters();
        logic [soc_pkg::data_width-1:0] d0;
        logic [soc_pkg::data_width-1:0] d1;
        logic [soc_pkg::data_width-1:0] r0;
        logic [soc_pkg::data_width-1:0] r1;
        d0 = random_word();
        d1 = random_word();
        run_both(slave_addr(soc_pkg::slave_gpio1, 0), 1'b1, d0,
                 slave_addr(soc_pkg::slave_gpio2, 0), 1'b1, d1, r0, r1);
        @(posedge clk);
        check_pins(current_pins(1), pin_max'(d0[soc_pkg::gpio1_pins-1:0]), "gpio1 from master 0");
        check_pins(current_pins(2), pin_max'(d1[soc_pkg::gpio2_pins-1:0]), "gpio2 from master 1");
        run_both(slave_addr(soc_pkg::slave_gpio1, 0), 1'b0, '0,
                 slave_addr(soc_pkg::slave_gpio2, 0), 1'b0, '0, r0, r1);
        check_data(r0, soc_pkg::data_width'(d0[soc_pkg::gpio1_pins-1:0]), "master 0 gpio1 read");
        check_data(r1, soc_pkg::data_width'(d1[soc_pkg::gpio2_pins-1:0]), "master 1 gpio2 read");
    endtask

    task automatic round_robin_fairness();
        logic [soc_pkg::data_width-1:0] data0 [fair_rounds];
        logic [soc_pkg::data_width-1:0] data1 [fair_rounds];
        logic [soc_pkg::data_width-1:0] r0;
        logic [soc_pkg::data_width-1:0] r1;
        int                             c0;
        int                             c1;
        // drawn up front so both branches see a fixed sequence
        for (int k = 0; k < fair_rounds; k++) begin
            data0[k] = random_word();
            data1[k] = random_word();
        end
        done_order.delete();
        fork
            for (int k = 0; k < fair_rounds; k++) begin
                apb_transfer(0, slave_addr(soc_pkg::slave_info, 2), 1'b1, data0[k], r0, c0);
                done_order.push_back(0);
            end
            for (int j = 0; j < fair_rounds; j++) begin
                apb_transfer(1, slave_addr(soc_pkg::slave_info, 3), 1'b1, data1[j], r1, c1);
                done_order.push_back(1);
            end
        join
        for (int i = 1; i < done_order.size(); i++) begin
            if (done_order[i] == done_order[i-1]) begin
                stop_on_failure($sformatf("ERROR at %0t: master %0d completed twice in a row",
                                          $time, done_order[i]));
            end
        end
        run_both(slave_addr(soc_pkg::slave_info, 2), 1'b0, '0,
                 slave_addr(soc_pkg::slave_info, 3), 1'b0, '0, r0, r1);
        check_data(r0, data0[fair_rounds-1], "scratch 2 after fairness run");
        check_data(r1, data1[fair_rounds-1], "scratch 3 after fairness run");
    endtask

    initial begin
        lfsr_state = 32'h1c04;
        reset      = 1'b1;
        for (int m = 0; m < soc_pkg::num_masters; m++) begin
            m_req[m] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        verify_reset_stretch();
        gpio_slave_check(soc_pkg::slave_gpio0, soc_pkg::gpio0_pins);
        gpio_slave_check(soc_pkg::slave_gpio1, soc_pkg::gpio1_pins);
        gpio_slave_check(soc_pkg::slave_gpio2, soc_pkg::gpio2_pins);
        info_register_checks();
        concurrent_masters();
        round_robin_fairness();
        $display("No errors");
        $finish;
    end

endmodule

// ==== src.f ====
verilog/soc_pkg.sv
verilog/reset_stretch.sv
verilog/apb_intercon.sv
verilog/gpio_apb.sv
verilog/info_regs_apb.sv
verilog/periph_soc.sv
testbench/tb_clock.sv
testbench/apb_intercon_properties.sv
testbench/periph_soc_tb.sv
